// ==== Makefile ====
# Verilator flow for the AXI4-Lite write splitter
# every variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= axil_wr_split_tb
RTL_TOP    ?= axil_wr_split
FILELIST   ?= axil_wr_split.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall
SIM_FLAGS  ?= --binary -j 0
PASS_TEXT  ?= Simulation PASSED

RTL_SRCS ?= source/axil_split_pkg.sv \
            source/axil_fifo.sv \
            source/axil_s_wr_fifos.sv \
            source/axil_m_wr_fifos.sv \
            source/axil_wr_split.sv

.PHONY: all lint sim clean

all: sim

# lint the RTL on its own with the design top
lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

# build and run the testbench, the log decides pass or fail
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== axil_wr_split.f ====
source/axil_split_pkg.sv
source/axil_fifo.sv
source/axil_s_wr_fifos.sv
source/axil_m_wr_fifos.sv
source/axil_wr_split.sv
sim/axil_wr_split_tb.sv

// ==== sim/axil_wr_split_tb.sv ====
`timescale 1ns/1ps

module axil_wr_split_tb;
  import axil_split_pkg::*;

  localparam int MAX_TESTS   = 32;
  localparam int WAIT_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 2000;

  // ------------------------------------------------------------------
  // clock, reset and the DUT pins
  // ------------------------------------------------------------------
  logic              aclk = 1'b0;
  logic              aresetn;
  logic              s_awvalid;
  logic              s_awready;
  logic [ADDR_W-1:0] s_awaddr;
  logic              s_wvalid;
  logic              s_wready;
  logic [DATA_W-1:0] s_wdata;
  logic [STRB_W-1:0] s_wstrb;
  logic              s_bvalid;
  logic              s_bready = 1'b0;
  logic [RESP_W-1:0] s_bresp;
  // master side pins indexed by port number
  logic [1:0]        m_awvalid;
  logic [1:0]        m_awready = '0;
  logic [ADDR_W-1:0] m_awaddr [2];
  logic [1:0]        m_wvalid;
  logic [1:0]        m_wready = '0;
  logic [DATA_W-1:0] m_wdata [2];
  logic [STRB_W-1:0] m_wstrb [2];
  logic [1:0]        m_bvalid = '0;
  logic [1:0]        m_bready;
  logic [RESP_W-1:0] m_bresp [2] = '{2'd0, 2'd0};

  // test table holding five hex words per line of the data file
  logic [31:0]       tests_mem [5*MAX_TESTS];
  logic [ADDR_W-1:0] t_addr [MAX_TESTS];
  logic [DATA_W-1:0] t_data [MAX_TESTS];
  logic [STRB_W-1:0] t_strb [MAX_TESTS];
  logic              t_port [MAX_TESTS];
  logic [RESP_W-1:0] t_resp [MAX_TESTS];
  int                n_tests;
  int                n_issued = 0;
  int                wr_idx = 0;
  int                b_idx = 0;
  int                errors = 0;
  int                timeouts = 0;
  logic              stop = 1'b0;

  // slave model state with one slot per port
  logic [31:0]       rnd;
  logic [1:0]        has_aw;
  logic [1:0]        has_w;
  logic [1:0]        pend;
  logic [ADDR_W-1:0] hold_addr [2];
  logic [DATA_W-1:0] hold_data [2];
  logic [STRB_W-1:0] hold_strb [2];
  logic [RESP_W-1:0] pend_resp [2];

  always #10 aclk = ~aclk;

  axil_wr_split u_dut (
    .aclk       (aclk),       .aresetn    (aresetn),
    .s_awvalid  (s_awvalid),  .s_awready  (s_awready),  .s_awaddr (s_awaddr),
    .s_wvalid   (s_wvalid),   .s_wready   (s_wready),
    .s_wdata    (s_wdata),    .s_wstrb    (s_wstrb),
    .s_bvalid   (s_bvalid),   .s_bready   (s_bready),   .s_bresp  (s_bresp),
    .m0_awvalid (m_awvalid[0]), .m0_awready (m_awready[0]), .m0_awaddr (m_awaddr[0]),
    .m0_wvalid  (m_wvalid[0]),  .m0_wready  (m_wready[0]),
    .m0_wdata   (m_wdata[0]),   .m0_wstrb   (m_wstrb[0]),
    .m0_bvalid  (m_bvalid[0]),  .m0_bready  (m_bready[0]),  .m0_bresp  (m_bresp[0]),
    .m1_awvalid (m_awvalid[1]), .m1_awready (m_awready[1]), .m1_awaddr (m_awaddr[1]),
    .m1_wvalid  (m_wvalid[1]),  .m1_wready  (m_wready[1]),
    .m1_wdata   (m_wdata[1]),   .m1_wstrb   (m_wstrb[1]),
    .m1_bvalid  (m_bvalid[1]),  .m1_bready  (m_bready[1]),  .m1_bresp  (m_bresp[1])
  );

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("error %s expected %h got %h", name, exp_val, act_val);
    errors++;
  endtask

  // the fill marks unused slots with a port word above 1
  task automatic load_tests();
    for (int i = 0; i < 5*MAX_TESTS; i++)
      tests_mem[i] = 32'hf000_0000 | 32'(i);
    $readmemh("sim/axil_wr_split_tests.txt", tests_mem);
    n_tests = 0;
    while (n_tests < MAX_TESTS && tests_mem[5*n_tests+3] <= 32'd1)
    begin
      t_addr[n_tests] = tests_mem[5*n_tests];
      t_data[n_tests] = tests_mem[5*n_tests+1];
      t_strb[n_tests] = tests_mem[5*n_tests+2][STRB_W-1:0];
      t_port[n_tests] = tests_mem[5*n_tests+3][0];
      t_resp[n_tests] = tests_mem[5*n_tests+4][RESP_W-1:0];
      // the port column has to agree with the split boundary
      if ((t_addr[n_tests] < axil_split_pkg::SPLIT_BASE) != (t_port[n_tests] == 1'b0))
      begin
        $display("test line %0d names a port that does not match its address", n_tests);
        errors++;
      end
      n_tests++;
    end
  endtask

  task automatic check_idle_outputs();
    if (s_bvalid !== 1'b0)
      report_mismatch("s_bvalid", 32'd0, 32'(s_bvalid));
    if (m_awvalid !== 2'b00)
      report_mismatch("m1_awvalid,m0_awvalid", 32'd0, 32'(m_awvalid));
    if (m_wvalid !== 2'b00)
      report_mismatch("m1_wvalid,m0_wvalid", 32'd0, 32'(m_wvalid));
    if (s_awready !== 1'b1)
      report_mismatch("s_awready", 32'd1, 32'(s_awready));
    if (s_wready !== 1'b1)
      report_mismatch("s_wready", 32'd1, 32'(s_wready));
    // empty master B FIFOs take responses right away
    if (m_bready !== 2'b11)
      report_mismatch("m1_bready,m0_bready", 32'h3, 32'(m_bready));
  endtask

  // a complete write at a slave must be the oldest one not yet seen
  task automatic check_arrival(input int port);
    if (wr_idx >= n_issued)
    begin
      $display("port %0d received a write that was never issued", port);
      errors++;
    end
    else
    begin
      if (int'(t_port[wr_idx]) != port)
      begin
        $display("write %0d arrived at port %0d instead of port %0d",
                 wr_idx, port, int'(t_port[wr_idx]));
        errors++;
      end
      if (hold_addr[port] !== t_addr[wr_idx])
        report_mismatch($sformatf("m%0d_awaddr", port), t_addr[wr_idx], hold_addr[port]);
      if (hold_data[port] !== t_data[wr_idx])
        report_mismatch($sformatf("m%0d_wdata", port), t_data[wr_idx], hold_data[port]);
      if (hold_strb[port] !== t_strb[wr_idx])
        report_mismatch($sformatf("m%0d_wstrb", port), 32'(t_strb[wr_idx]),
                        32'(hold_strb[port]));
      wr_idx++;
    end
  endtask

  // AW and W go up together and drop one by one as each is taken
  task automatic drive_write(input int idx);
    logic aw_pend;
    logic w_pend;
    logic aw_hs;
    logic w_hs;
    int   cycles;
    n_issued = idx + 1;
    @(posedge aclk);
    s_awvalid <= 1'b1;
    s_awaddr  <= t_addr[idx];
    s_wvalid  <= 1'b1;
    s_wdata   <= t_data[idx];
    s_wstrb   <= t_strb[idx];
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    cycles  = 0;
    while ((aw_pend || w_pend) && cycles < WAIT_LIMIT)
    begin
      // ready is sampled mid cycle where it has settled
      @(negedge aclk);
      aw_hs = aw_pend && s_awready;
      w_hs  = w_pend && s_wready;
      @(posedge aclk);
      if (aw_hs)
      begin
        s_awvalid <= 1'b0;
        aw_pend = 1'b0;
      end
      if (w_hs)
      begin
        s_wvalid <= 1'b0;
        w_pend = 1'b0;
      end
      cycles++;
    end
    if (aw_pend || w_pend)
    begin
      $display("timed out waiting for the slave port to accept write %0d", idx);
      timeouts++;
      stop = 1'b1;
    end
  endtask

  // ------------------------------------------------------------------
  // slave models and the response checker share one random stream
  // ------------------------------------------------------------------
  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      rnd       <= 32'h8b80;
      s_bready  <= 1'b0;
      m_awready <= '0;
      m_wready  <= '0;
      m_bvalid  <= '0;
      has_aw = '0;
      has_w  = '0;
      pend   = '0;
    end
    else
    begin
      rnd <= next_random(rnd);
      // s_bready is low three cycles out of four so the B FIFOs back up
      s_bready <= rnd[8] & rnd[9];
      if (s_bvalid && s_bready)
      begin
        if (b_idx >= n_issued)
        begin
          $display("s_bresp delivered a response with no write outstanding");
          errors++;
        end
        else if (s_bresp !== t_resp[b_idx])
          report_mismatch("s_bresp", 32'(t_resp[b_idx]), 32'(s_bresp));
        b_idx++;
      end
      for (int j = 0; j < 2; j++)
      begin
        if (m_awvalid[j] && m_awready[j])
        begin
          hold_addr[j] = m_awaddr[j];
          has_aw[j] = 1'b1;
        end
        if (m_wvalid[j] && m_wready[j])
        begin
          hold_data[j] = m_wdata[j];
          hold_strb[j] = m_wstrb[j];
          has_w[j] = 1'b1;
        end
        // each slave holds one response at a time and port 1 flags partial strobes
        if (has_aw[j] && has_w[j] && !pend[j])
        begin
          check_arrival(j);
          pend_resp[j] = (j == 1 && hold_strb[j] != '1) ? axil_split_pkg::RESP_SLVERR
                                                        : axil_split_pkg::RESP_OKAY;
          pend[j]   = 1'b1;
          has_aw[j] = 1'b0;
          has_w[j]  = 1'b0;
        end
        if (m_bvalid[j] && m_bready[j])
          m_bvalid[j] <= 1'b0;
        if (pend[j] && (!m_bvalid[j] || m_bready[j]) && rnd[4*j+2])
        begin
          m_bvalid[j] <= 1'b1;
          m_bresp[j]  <= pend_resp[j];
          pend[j] = 1'b0;
        end
        m_awready[j] <= !has_aw[j] && rnd[4*j];
        m_wready[j]  <= !has_w[j] && rnd[4*j+1];
      end
    end
  end

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial
  begin
    int cycles;
    aresetn   = 1'b0;
    s_awvalid = 1'b0;
    s_awaddr  = '0;
    s_wvalid  = 1'b0;
    s_wdata   = '0;
    s_wstrb   = '0;
    load_tests();
    if (n_tests == 0)
    begin
      $display("the test file holds no writes");
      errors++;
    end
    // reset stays low for three edges and the outputs are checked inside and after it
    @(posedge aclk);
    @(negedge aclk);
    check_idle_outputs();
    repeat (2) @(posedge aclk);
    aresetn <= 1'b1;
    @(negedge aclk);
    check_idle_outputs();
    for (int i = 0; i < n_tests && !stop; i++)
      drive_write(i);
    cycles = 0;
    while (b_idx < n_tests && cycles < DRAIN_LIMIT)
    begin
      @(posedge aclk);
      cycles++;
    end
    if (b_idx < n_tests)
    begin
      $display("timed out waiting for responses, %0d of %0d arrived", b_idx, n_tests);
      timeouts++;
    end
    // a quiet stretch catches any write that shows up twice
    repeat (20) @(posedge aclk);
    if (wr_idx != n_tests)
    begin
      $display("the slaves received %0d writes where %0d were sent", wr_idx, n_tests);
      errors++;
    end
    if (b_idx != n_tests)
    begin
      $display("s_bresp carried %0d responses where %0d were expected", b_idx, n_tests);
      errors++;
    end
    $display("errors %0d timeouts %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== sim/axil_wr_split_tests.txt ====
// columns: address data strobe port response, all hex, one write per line
// port 0 below 00008000, response 2 is SLVERR for a partial strobe on port 1
00000000 11110000 f 0 0
00000004 11110001 3 0 0
00000008 11110002 f 0 0
0000000c 11110003 1 0 0
00000010 11110004 f 0 0
00000014 11110005 c 0 0
00008000 22220000 f 1 0
00008004 22220001 7 1 2
00008008 22220002 f 1 0
0000800c 22220003 f 1 0
00008010 22220004 8 1 2
00008014 22220005 f 1 0
00007ffc 33330000 f 0 0
0000c000 33330001 f 1 0
00000100 33330002 e 0 0
0001fff0 33330003 3 1 2
00004000 33330004 f 0 0
ffff0000 33330005 f 1 0
00007ff8 44440000 6 0 0
00008020 44440001 f 1 0
00000200 44440002 f 0 0
80000000 44440003 1 1 2

// ==== source/axil_fifo.sv ====
`timescale 1ns/1ps

module axil_fifo #(
  parameter int WIDTH = 8
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  output logic             full,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty
);
  import axil_split_pkg::*;

  // circular buffer storage, the head sits at rd_ptr
  logic [WIDTH-1:0]                mem [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0]   wr_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0]   rd_ptr;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count;
  logic [$clog2(FIFO_DEPTH+1)-1:0] count_nxt;
  logic                            push;
  logic                            pop;

  // a push into a full FIFO or a pop from an empty one does nothing
  assign push = wr_en && !full;
  assign pop  = rd_en && !empty;

  // first word fall through, the head needs no read strobe
  assign rd_data = mem[rd_ptr];

  always_comb
  begin
    case ({push, pop})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  // pointers, occupancy and the registered flags
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      full   <= 1'b0;
      empty  <= 1'b1;
    end
    else
    begin
      if (push)
        wr_ptr <= (int'(wr_ptr) == FIFO_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (int'(rd_ptr) == FIFO_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      count <= count_nxt;
      // flags follow the next occupancy so they are valid right after the edge
      full  <= (int'(count_nxt) == FIFO_DEPTH);
      empty <= (count_nxt == '0);
    end
  end

  // the pushed word lands at the head one cycle later
  always_ff @(posedge aclk)
  begin
    if (push)
      mem[wr_ptr] <= wr_data;
  end

endmodule

// ==== source/axil_m_wr_fifos.sv ====
`timescale 1ns/1ps

module axil_m_wr_fifos (
  input  logic                            aclk,
  input  logic                            aresetn,
  // AXI4-Lite master write channels
  output logic                            m_awvalid,
  input  logic                            m_awready,
  output logic [axil_split_pkg::ADDR_W-1:0] m_awaddr,
  output logic                            m_wvalid,
  input  logic                            m_wready,
  output logic [axil_split_pkg::DATA_W-1:0] m_wdata,
  output logic [axil_split_pkg::STRB_W-1:0] m_wstrb,
  input  logic                            m_bvalid,
  output logic                            m_bready,
  input  logic [axil_split_pkg::RESP_W-1:0] m_bresp,
  // router side, address and data are written, responses are read
  input  logic                            aw_wr_en,
  input  logic [axil_split_pkg::ADDR_W-1:0] aw_wr_addr,
  output logic                            aw_wr_full,
  input  logic                            w_wr_en,
  input  logic [axil_split_pkg::DATA_W-1:0] w_wr_data,
  input  logic [axil_split_pkg::STRB_W-1:0] w_wr_strb,
  output logic                            w_wr_full,
  input  logic                            b_rd_en,
  output logic [axil_split_pkg::RESP_W-1:0] b_rd_resp,
  output logic                            b_rd_empty
);
  import axil_split_pkg::*;

  logic                     aw_empty;
  logic                     w_empty;
  logic                     b_full;
  logic [STRB_W+DATA_W-1:0] w_head;

  // ------------------------------------------------------------------
  // AW and W leave on their own, the slave may take them in any order
  // ------------------------------------------------------------------
  assign m_awvalid = !aw_empty;
  assign m_wvalid  = !w_empty;

  // the head stays put until the slave accepts it, which keeps the
  // payload stable while valid is high
  axil_fifo #(.WIDTH(ADDR_W)) u_aw_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (aw_wr_en),
    .wr_data (aw_wr_addr),
    .full    (aw_wr_full),
    .rd_en   (m_awvalid && m_awready),
    .rd_data (m_awaddr),
    .empty   (aw_empty)
  );

  axil_fifo #(.WIDTH(STRB_W + DATA_W)) u_w_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (w_wr_en),
    .wr_data ({w_wr_strb, w_wr_data}),
    .full    (w_wr_full),
    .rd_en   (m_wvalid && m_wready),
    .rd_data (w_head),
    .empty   (w_empty)
  );

  assign {m_wstrb, m_wdata} = w_head;

  // ------------------------------------------------------------------
  // B, responses are taken while there is room and held for the router
  // ------------------------------------------------------------------
  assign m_bready = !b_full;

  axil_fifo #(.WIDTH(RESP_W)) u_b_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (m_bvalid && m_bready),
    .wr_data (m_bresp),
    .full    (b_full),
    .rd_en   (b_rd_en),
    .rd_data (b_rd_resp),
    .empty   (b_rd_empty)
  );

endmodule

// ==== source/axil_s_wr_fifos.sv ====
`timescale 1ns/1ps

module axil_s_wr_fifos (
  input  logic                            aclk,
  input  logic                            aresetn,
  // AXI4-Lite slave write channels
  input  logic                            s_awvalid,
  output logic                            s_awready,
  input  logic [axil_split_pkg::ADDR_W-1:0] s_awaddr,
  input  logic                            s_wvalid,
  output logic                            s_wready,
  input  logic [axil_split_pkg::DATA_W-1:0] s_wdata,
  input  logic [axil_split_pkg::STRB_W-1:0] s_wstrb,
  output logic                            s_bvalid,
  input  logic                            s_bready,
  output logic [axil_split_pkg::RESP_W-1:0] s_bresp,
  // router side, address and data are read, responses are written
  input  logic                            aw_rd_en,
  output logic [axil_split_pkg::ADDR_W-1:0] aw_rd_addr,
  output logic                            aw_rd_empty,
  input  logic                            w_rd_en,
  output logic [axil_split_pkg::DATA_W-1:0] w_rd_data,
  output logic [axil_split_pkg::STRB_W-1:0] w_rd_strb,
  output logic                            w_rd_empty,
  input  logic                            b_wr_en,
  input  logic [axil_split_pkg::RESP_W-1:0] b_wr_resp,
  output logic                            b_wr_full
);
  import axil_split_pkg::*;

  logic                     aw_full;
  logic                     w_full;
  logic                     b_empty;
  logic [STRB_W+DATA_W-1:0] w_head;

  // ------------------------------------------------------------------
  // AW and W, ready whenever the FIFO has room
  // ------------------------------------------------------------------
  assign s_awready = !aw_full;
  assign s_wready  = !w_full;

  axil_fifo #(.WIDTH(ADDR_W)) u_aw_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (s_awvalid && s_awready),
    .wr_data (s_awaddr),
    .full    (aw_full),
    .rd_en   (aw_rd_en),
    .rd_data (aw_rd_addr),
    .empty   (aw_rd_empty)
  );

  // the strobe rides in the upper bits of the W entry
  axil_fifo #(.WIDTH(STRB_W + DATA_W)) u_w_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (s_wvalid && s_wready),
    .wr_data ({s_wstrb, s_wdata}),
    .full    (w_full),
    .rd_en   (w_rd_en),
    .rd_data (w_head),
    .empty   (w_rd_empty)
  );

  assign {w_rd_strb, w_rd_data} = w_head;

  // ------------------------------------------------------------------
  // B, the head is offered as long as the FIFO holds a response
  // ------------------------------------------------------------------
  assign s_bvalid = !b_empty;

  axil_fifo #(.WIDTH(RESP_W)) u_b_fifo (
    .aclk    (aclk),
    .aresetn (aresetn),
    .wr_en   (b_wr_en),
    .wr_data (b_wr_resp),
    .full    (b_wr_full),
    .rd_en   (s_bvalid && s_bready),
    .rd_data (s_bresp),
    .empty   (b_empty)
  );

endmodule

// ==== source/axil_split_pkg.sv ====
package axil_split_pkg;

  // ------------------------------------------------------------------
  // bus widths of the AXI4-Lite write channels
  // ------------------------------------------------------------------
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  // one strobe bit per data byte
  localparam int STRB_W = DATA_W / 8;
  localparam int RESP_W = 2;

  // write response codes as carried on bresp
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;

  // addresses strictly below this boundary route to master port 0
  localparam logic [ADDR_W-1:0] SPLIT_BASE = 32'h0000_8000;

  // every channel FIFO on both sides has this many entries
  localparam int FIFO_DEPTH = 4;

  // outstanding response counter, wide enough to hold FIFO_DEPTH
  localparam int RESP_CNT_W = 3;

  // ------------------------------------------------------------------
  // one-hot codes of the routing FSM
  // ------------------------------------------------------------------
  localparam logic [3:0] IDLE    = 4'b0001;
  localparam logic [3:0] LO_ADDR = 4'b0010;
  localparam logic [3:0] HI_ADDR = 4'b0100;
  localparam logic [3:0] FLUSH   = 4'b1000;

endpackage

// ==== source/axil_wr_split.sv ====
`timescale 1ns/1ps

module axil_wr_split (
  input  logic                            aclk,
  input  logic                            aresetn,
  // slave port
  input  logic                            s_awvalid,
  output logic                            s_awready,
  input  logic [axil_split_pkg::ADDR_W-1:0] s_awaddr,
  input  logic                            s_wvalid,
  output logic                            s_wready,
  input  logic [axil_split_pkg::DATA_W-1:0] s_wdata,
  input  logic [axil_split_pkg::STRB_W-1:0] s_wstrb,
  output logic                            s_bvalid,
  input  logic                            s_bready,
  output logic [axil_split_pkg::RESP_W-1:0] s_bresp,
  // master port 0, addresses below the split boundary
  output logic                            m0_awvalid,
  input  logic                            m0_awready,
  output logic [axil_split_pkg::ADDR_W-1:0] m0_awaddr,
  output logic                            m0_wvalid,
  input  logic                            m0_wready,
  output logic [axil_split_pkg::DATA_W-1:0] m0_wdata,
  output logic [axil_split_pkg::STRB_W-1:0] m0_wstrb,
  input  logic                            m0_bvalid,
  output logic                            m0_bready,
  input  logic [axil_split_pkg::RESP_W-1:0] m0_bresp,
  // master port 1, the boundary and above
  output logic                            m1_awvalid,
  input  logic                            m1_awready,
  output logic [axil_split_pkg::ADDR_W-1:0] m1_awaddr,
  output logic                            m1_wvalid,
  input  logic                            m1_wready,
  output logic [axil_split_pkg::DATA_W-1:0] m1_wdata,
  output logic [axil_split_pkg::STRB_W-1:0] m1_wstrb,
  input  logic                            m1_bvalid,
  output logic                            m1_bready,
  input  logic [axil_split_pkg::RESP_W-1:0] m1_bresp
);
  import axil_split_pkg::*;

  // slave side FIFO group
  logic              aw_rd_en;
  logic [ADDR_W-1:0] aw_rd_addr;
  logic              aw_rd_empty;
  logic              w_rd_en;
  logic [DATA_W-1:0] w_rd_data;
  logic [STRB_W-1:0] w_rd_strb;
  logic              w_rd_empty;
  logic              b_wr_en;
  logic [RESP_W-1:0] b_wr_resp;
  logic              b_wr_full;

  // master ports and their FIFO groups, indexed by port number
  logic [1:0]             m_awvalid;
  logic [1:0]             m_awready;
  logic [1:0][ADDR_W-1:0] m_awaddr;
  logic [1:0]             m_wvalid;
  logic [1:0]             m_wready;
  logic [1:0][DATA_W-1:0] m_wdata;
  logic [1:0][STRB_W-1:0] m_wstrb;
  logic [1:0]             m_bvalid;
  logic [1:0]             m_bready;
  logic [1:0][RESP_W-1:0] m_bresp;
  logic [1:0]             m_aw_wr_en;
  logic [1:0]             m_aw_wr_full;
  logic [1:0]             m_w_wr_en;
  logic [1:0]             m_w_wr_full;
  logic [1:0]             m_b_rd_en;
  logic [1:0][RESP_W-1:0] m_b_rd_resp;
  logic [1:0]             m_b_rd_empty;

  // routing control
  logic [3:0]            state;
  logic [3:0]            next_state;
  logic [3:0]            want_state;
  logic [1:0]            route;
  logic                  fwd_ok;
  logic [RESP_CNT_W-1:0] resp_cnt;
  logic                  resp_done;

  axil_s_wr_fifos u_s_fifos (.*);

  // master port pins map onto the indexed vectors
  assign {m1_awvalid, m0_awvalid} = m_awvalid;
  assign {m1_awaddr, m0_awaddr}   = m_awaddr;
  assign {m1_wvalid, m0_wvalid}   = m_wvalid;
  assign {m1_wdata, m0_wdata}     = m_wdata;
  assign {m1_wstrb, m0_wstrb}     = m_wstrb;
  assign {m1_bready, m0_bready}   = m_bready;
  assign m_awready = {m1_awready, m0_awready};
  assign m_wready  = {m1_wready, m0_wready};
  assign m_bvalid  = {m1_bvalid, m0_bvalid};
  assign m_bresp   = {m1_bresp, m0_bresp};

  // ------------------------------------------------------------------
  // routing FSM
  // ------------------------------------------------------------------

  // the port the head write wants, as a state code
  assign want_state = (aw_rd_addr < SPLIT_BASE) ? LO_ADDR : HI_ADDR;
  assign resp_done  = (resp_cnt == '0);

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      state <= IDLE;
    else
      state <= next_state;
  end

  always_comb
  begin
    next_state = state;
    case (state)
      IDLE:
      begin
        // IDLE is only entered with nothing outstanding
        if (!aw_rd_empty)
          next_state = want_state;
      end
      LO_ADDR, HI_ADDR:
      begin
        // a head for the other port means drain the current one first
        if (!aw_rd_empty && want_state != state)
          next_state = FLUSH;
      end
      FLUSH:
      begin
        if (resp_done)
          next_state = aw_rd_empty ? IDLE : want_state;
      end
      default:
        next_state = IDLE;
    endcase
  end

  // routing follows the next state so a switch costs no extra cycle
  assign route[0] = (next_state == LO_ADDR);
  assign route[1] = (next_state == HI_ADDR);

  // both heads present and room left to count another response
  assign fwd_ok = !aw_rd_empty && !w_rd_empty && (resp_cnt < RESP_CNT_W'(FIFO_DEPTH));

  // ------------------------------------------------------------------
  // master FIFO groups and transfer enables
  // ------------------------------------------------------------------
  for (genvar j = 0; j < 2; j++)
  begin : g_m_port
    // AW and W move together so the two heads stay paired
    assign m_aw_wr_en[j] = route[j] && fwd_ok && !m_aw_wr_full[j] && !m_w_wr_full[j];
    assign m_w_wr_en[j]  = m_aw_wr_en[j];
    // only one port holds responses at a time, so no arbitration here
    assign m_b_rd_en[j]  = !m_b_rd_empty[j] && !b_wr_full;

    axil_m_wr_fifos u_m_fifos (
      .aclk       (aclk),
      .aresetn    (aresetn),
      .m_awvalid  (m_awvalid[j]),
      .m_awready  (m_awready[j]),
      .m_awaddr   (m_awaddr[j]),
      .m_wvalid   (m_wvalid[j]),
      .m_wready   (m_wready[j]),
      .m_wdata    (m_wdata[j]),
      .m_wstrb    (m_wstrb[j]),
      .m_bvalid   (m_bvalid[j]),
      .m_bready   (m_bready[j]),
      .m_bresp    (m_bresp[j]),
      .aw_wr_en   (m_aw_wr_en[j]),
      .aw_wr_addr (aw_rd_addr),
      .aw_wr_full (m_aw_wr_full[j]),
      .w_wr_en    (m_w_wr_en[j]),
      .w_wr_data  (w_rd_data),
      .w_wr_strb  (w_rd_strb),
      .w_wr_full  (m_w_wr_full[j]),
      .b_rd_en    (m_b_rd_en[j]),
      .b_rd_resp  (m_b_rd_resp[j]),
      .b_rd_empty (m_b_rd_empty[j])
    );
  end

  // slave side pops on any forward and pushes on any response move
  assign aw_rd_en  = |m_aw_wr_en;
  assign w_rd_en   = |m_w_wr_en;
  assign b_wr_en   = |m_b_rd_en;
  assign b_wr_resp = m_b_rd_empty[0] ? m_b_rd_resp[1] : m_b_rd_resp[0];

  // ------------------------------------------------------------------
  // outstanding responses, forwarded but not yet in the slave B FIFO
  // ------------------------------------------------------------------
  always_ff @(posedge aclk)
  begin
    if (!aresetn)
      resp_cnt <= '0;
    else
    begin
      case ({aw_rd_en, b_wr_en})
        2'b10:   resp_cnt <= resp_cnt + 1'b1;
        2'b01:   resp_cnt <= resp_cnt - 1'b1;
        default: resp_cnt <= resp_cnt;
      endcase
    end
  end

endmodule
